//--- common/clock_sync_pkg.sv
package clock_sync_pkg;

	// ============================================================
	// widths and basic types
	// ============================================================

	// timestamps, offsets and delays all share one width
	parameter int TS_W = 16;

	typedef logic [TS_W-1:0] ts_t;

	typedef logic [7:0] byte_t;

	// mailbox address space seen on the receive port
	parameter int ADDR_W = 10;

	typedef logic [ADDR_W-1:0] addr_t;

	// ============================================================
	// node message layout
	// ============================================================

	// four timestamps per node, each stored as two byte lanes
	parameter int SLOTS_PER_NODE = 4;

	// flag word occupies bytes 2 and 3 of a node message
	parameter int FLAGS_OFS = 2;

	// slot k sits at TS_OFS + 2k (low byte) and one above (high byte)
	parameter int TS_OFS = 4;

	// bit positions inside the flag word
	parameter int FLAG_SYNC  = 0;
	parameter int FLAG_READY = 1;
	parameter int FLAG_SCOPE = 2;

	// half-range correction applied to the offset on a counter wrap
	parameter ts_t WRAP_ADD = 16'h8000;

endpackage

//--- master_sync/mailbox_decoder.sv
`timescale 1ns/1ps

module mailbox_decoder #(
	parameter int NODES = 4,
	parameter int BASE_ADDR = 64,
	parameter int MSG_LEN = 16,
	localparam int TS_AW = $clog2(NODES * clock_sync_pkg::SLOTS_PER_NODE)
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  rx_we_i,
	input  clock_sync_pkg::addr_t rx_addr_i,
	input  clock_sync_pkg::byte_t rx_data_i,
	input  logic                  cycle_pulse_i,
	output logic                  ts_we_lo_o,
	output logic                  ts_we_hi_o,
	output logic [TS_AW-1:0]      ts_waddr_o,
	output logic [NODES-1:0]      rx_ok_o,
	output logic [NODES-1:0]      sync_ok_o,
	output logic [NODES-1:0]      slave_rdy_o,
	output logic [NODES-1:0]      scope_trigger_o
);
	import clock_sync_pkg::*;

	localparam int NW = $clog2(NODES);
	localparam int SLOT_W = $clog2(SLOTS_PER_NODE);
	localparam int REGION_LEN = NODES * MSG_LEN;

	addr_t rel;
	addr_t ofs;
	addr_t ts_rel;
	logic [NW-1:0] node;
	logic in_region;
	logic is_ts;
	logic wr_lo;
	logic wr_hi;
	logic flag_lo_wr;
	logic flag_hi_wr;
	logic pred_ok;

	logic [NODES-1:0] lo_seen_q;
	logic [NODES-1:0] hi_seen_q;
	logic [NODES-1:0] complete;
	logic [NODES-1:0][TS_W-1:0] flags_q;
	logic [NODES-1:0] sync_flag;
	logic [NODES-1:0] ready_flag;
	logic [NODES-1:0] scope_flag;

	// ============================================================
	// address decode
	// ============================================================

	assign rel = rx_addr_i - addr_t'(BASE_ADDR);
	assign in_region = (rx_addr_i >= BASE_ADDR) && (rel < REGION_LEN);
	assign node = NW'(rel / MSG_LEN);
	assign ofs = addr_t'(rel % MSG_LEN);

	assign ts_rel = ofs - addr_t'(TS_OFS);
	assign is_ts = (ofs >= TS_OFS) && (ofs < TS_OFS + 2 * SLOTS_PER_NODE);

	// even offsets from TS_OFS are low bytes
	assign wr_lo = rx_we_i && in_region && is_ts && !ts_rel[0];
	assign wr_hi = rx_we_i && in_region && is_ts && ts_rel[0];
	assign flag_lo_wr = rx_we_i && in_region && (ofs == FLAGS_OFS);
	assign flag_hi_wr = rx_we_i && in_region && (ofs == FLAGS_OFS + 1);

	assign ts_we_lo_o = wr_lo;
	assign ts_we_hi_o = wr_hi;
	assign ts_waddr_o = {node, ts_rel[SLOT_W:1]};

	// ============================================================
	// completion chain and status
	// ============================================================

	assign complete = lo_seen_q & hi_seen_q;

	// a node only counts once every node before it is complete
	assign pred_ok = (node == '0) || complete[node - 1'b1];

	always_comb begin
		for (int n = 0; n < NODES; n++) begin
			sync_flag[n] = flags_q[n][FLAG_SYNC];
			ready_flag[n] = flags_q[n][FLAG_READY];
			scope_flag[n] = flags_q[n][FLAG_SCOPE];
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			lo_seen_q <= '0;
			hi_seen_q <= '0;
			flags_q <= '0;
			rx_ok_o <= '0;
			sync_ok_o <= '0;
			slave_rdy_o <= '0;
			scope_trigger_o <= '0;
		end else if (cycle_pulse_i) begin
			rx_ok_o <= complete;
			sync_ok_o <= complete & sync_flag;
			slave_rdy_o <= complete & sync_flag & ready_flag;
			scope_trigger_o <= complete & scope_flag;
			// start the next cycle from a clean slate
			lo_seen_q <= '0;
			hi_seen_q <= '0;
			flags_q <= '0;
		end else begin
			if (wr_lo && pred_ok) begin
				lo_seen_q[node] <= 1'b1;
			end
			if (wr_hi && pred_ok && lo_seen_q[node]) begin
				hi_seen_q[node] <= 1'b1;
			end
			if (flag_lo_wr) begin
				flags_q[node][7:0] <= rx_data_i;
			end
			if (flag_hi_wr) begin
				flags_q[node][TS_W-1:8] <= rx_data_i;
			end
		end
	end

endmodule

//--- master_sync/timestamp_ram.sv
`timescale 1ns/1ps

module timestamp_ram #(
	parameter int NODES = 4,
	localparam int TS_AW = $clog2(NODES * clock_sync_pkg::SLOTS_PER_NODE)
) (
	input  logic                  clk_i,
	input  logic                  we_lo_i,
	input  logic                  we_hi_i,
	input  logic [TS_AW-1:0]      waddr_i,
	input  clock_sync_pkg::byte_t wdata_i,
	input  logic [TS_AW-1:0]      raddr_i,
	output clock_sync_pkg::ts_t   rdata_o
);
	import clock_sync_pkg::*;

	localparam int DEPTH = NODES * SLOTS_PER_NODE;
	localparam int LANES = 2;

	// lane 0 keeps the low bytes, lane 1 the high bytes
	byte_t mem_q [LANES][DEPTH];
	logic [LANES-1:0] lane_we;

	assign lane_we = {we_hi_i, we_lo_i};

	always_ff @(posedge clk_i) begin
		for (int l = 0; l < LANES; l++) begin
			if (lane_we[l]) begin
				mem_q[l][waddr_i] <= wdata_i;
			end
		end
	end

	// read port is asynchronous so the sequencer sees data in the same cycle
	assign rdata_o = {mem_q[1][raddr_i], mem_q[0][raddr_i]};

endmodule

//--- master_sync/offset_delay_seq.sv
`timescale 1ns/1ps

module offset_delay_seq #(
	parameter int NODES = 4,
	localparam int NW = $clog2(NODES),
	localparam int TS_AW = $clog2(NODES * clock_sync_pkg::SLOTS_PER_NODE)
) (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                cycle_pulse_i,
	input  clock_sync_pkg::ts_t snap_tx_i,
	input  clock_sync_pkg::ts_t snap_rx_i,
	input  clock_sync_pkg::ts_t rdata_i,
	input  logic                result_ready_i,
	output logic [TS_AW-1:0]    raddr_o,
	output logic                result_valid_o,
	output logic [NW-1:0]       result_node_o,
	output clock_sync_pkg::ts_t result_offset_o,
	output clock_sync_pkg::ts_t result_delay_o,
	output logic                busy_o
);
	import clock_sync_pkg::*;

	localparam int SLOT_W = $clog2(SLOTS_PER_NODE);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_OP_A,
		ST_OP_B,
		ST_OP_C,
		ST_OP_D,
		ST_CORR,
		ST_OUT
	} state_t;

	state_t state_q;
	logic [NW-1:0] node_q;
	logic [TS_AW-1:0] base_addr;
	logic first_node;
	logic accumulate;
	logic wrap_fix;
	ts_t operand;
	ts_t snap_tx_q;
	ts_t snap_rx_q;
	ts_t delay_q;
	ts_t offset_q;
	logic [3:0] sign_q;

	// ============================================================
	// operand fetch
	// ============================================================

	assign base_addr = {node_q, SLOT_W'(0)};
	assign first_node = (node_q == '0);

	// c and d come from slots 2 and 3 of the previous node
	always_comb begin
		case (state_q)
			ST_OP_B: raddr_o = base_addr + TS_AW'(1);
			ST_OP_C: raddr_o = base_addr - TS_AW'(2);
			ST_OP_D: raddr_o = base_addr - TS_AW'(1);
			default: raddr_o = base_addr;
		endcase
	end

	// node 0 has no predecessor, the local snapshots take its place
	always_comb begin
		operand = rdata_i;
		if (first_node && state_q == ST_OP_C) begin
			operand = snap_tx_q;
		end
		if (first_node && state_q == ST_OP_D) begin
			operand = snap_rx_q;
		end
	end

	assign accumulate = (state_q == ST_OP_A) || (state_q == ST_OP_B) ||
		(state_q == ST_OP_C) || (state_q == ST_OP_D);

	// sign_q ends up as bit 14 of d, c, b, a from msb down
	assign wrap_fix = (sign_q == 4'b0100) || (sign_q == 4'b0010) || (sign_q == 4'b0111);

	// ============================================================
	// control
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			node_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (cycle_pulse_i) begin
						state_q <= ST_OP_A;
					end
				end
				ST_OP_A: state_q <= ST_OP_B;
				ST_OP_B: state_q <= ST_OP_C;
				ST_OP_C: state_q <= ST_OP_D;
				ST_OP_D: state_q <= ST_CORR;
				ST_CORR: state_q <= ST_OUT;
				ST_OUT: begin
					if (result_ready_i) begin
						// index wraps back to 0 after the last node
						node_q <= node_q + 1'b1;
						if (node_q == NW'(NODES - 1)) begin
							state_q <= ST_IDLE;
						end else begin
							state_q <= ST_OP_A;
						end
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// ============================================================
	// datapath
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && cycle_pulse_i) begin
			snap_tx_q <= snap_tx_i;
			snap_rx_q <= snap_rx_i;
		end
		if (accumulate) begin
			sign_q <= {operand[TS_W-2], sign_q[3:1]};
		end
		case (state_q)
			ST_OP_A: begin
				delay_q <= operand;
				offset_q <= operand;
			end
			ST_OP_B: begin
				delay_q <= delay_q - operand;
				offset_q <= offset_q + operand;
			end
			ST_OP_C: begin
				delay_q <= delay_q - operand;
				offset_q <= offset_q - operand;
			end
			ST_OP_D: begin
				delay_q <= delay_q + operand;
				offset_q <= offset_q - operand;
			end
			ST_CORR: begin
				if (wrap_fix) begin
					offset_q <= offset_q + WRAP_ADD;
				end
			end
			default: begin
			end
		endcase
	end

	assign result_valid_o = (state_q == ST_OUT);
	assign result_node_o = node_q;
	assign result_offset_o = offset_q;
	assign result_delay_o = delay_q;
	assign busy_o = (state_q != ST_IDLE);

endmodule

//--- master_sync/master_sync.sv
`timescale 1ns/1ps

module master_sync #(
	parameter int NODES = 4,
	parameter int BASE_ADDR = 64,
	parameter int MSG_LEN = 16,
	localparam int NW = $clog2(NODES)
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  rx_we_i,
	input  clock_sync_pkg::addr_t rx_addr_i,
	input  clock_sync_pkg::byte_t rx_data_i,
	input  logic                  cycle_pulse_i,
	input  clock_sync_pkg::ts_t   snap_tx_i,
	input  clock_sync_pkg::ts_t   snap_rx_i,
	input  logic                  result_ready_i,
	output logic [NODES-1:0]      rx_ok_o,
	output logic [NODES-1:0]      sync_ok_o,
	output logic [NODES-1:0]      slave_rdy_o,
	output logic [NODES-1:0]      scope_trigger_o,
	output logic                  result_valid_o,
	output logic [NW-1:0]         result_node_o,
	output clock_sync_pkg::ts_t   result_offset_o,
	output clock_sync_pkg::ts_t   result_delay_o,
	output logic                  busy_o
);
	import clock_sync_pkg::*;

	localparam int TS_AW = $clog2(NODES * SLOTS_PER_NODE);

	logic ts_we_lo;
	logic ts_we_hi;
	logic [TS_AW-1:0] ts_waddr;
	logic [TS_AW-1:0] ts_raddr;
	ts_t ts_rdata;

	mailbox_decoder #(
		.NODES(NODES),
		.BASE_ADDR(BASE_ADDR),
		.MSG_LEN(MSG_LEN)
	) u_mailbox_decoder (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rx_we_i(rx_we_i),
		.rx_addr_i(rx_addr_i),
		.rx_data_i(rx_data_i),
		.cycle_pulse_i(cycle_pulse_i),
		.ts_we_lo_o(ts_we_lo),
		.ts_we_hi_o(ts_we_hi),
		.ts_waddr_o(ts_waddr),
		.rx_ok_o(rx_ok_o),
		.sync_ok_o(sync_ok_o),
		.slave_rdy_o(slave_rdy_o),
		.scope_trigger_o(scope_trigger_o)
	);

	// both lanes take the receive byte straight from the port
	timestamp_ram #(
		.NODES(NODES)
	) u_timestamp_ram (
		.clk_i(clk_i),
		.we_lo_i(ts_we_lo),
		.we_hi_i(ts_we_hi),
		.waddr_i(ts_waddr),
		.wdata_i(rx_data_i),
		.raddr_i(ts_raddr),
		.rdata_o(ts_rdata)
	);

	offset_delay_seq #(
		.NODES(NODES)
	) u_offset_delay_seq (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.cycle_pulse_i(cycle_pulse_i),
		.snap_tx_i(snap_tx_i),
		.snap_rx_i(snap_rx_i),
		.rdata_i(ts_rdata),
		.result_ready_i(result_ready_i),
		.raddr_o(ts_raddr),
		.result_valid_o(result_valid_o),
		.result_node_o(result_node_o),
		.result_offset_o(result_offset_o),
		.result_delay_o(result_delay_o),
		.busy_o(busy_o)
	);

endmodule

//--- tests/master_sync_vectors.svh
`ifndef MASTER_SYNC_VECTORS_SVH
`define MASTER_SYNC_VECTORS_SVH

// each entry is one case and ts[n][k] holds node n slot k
// bit n of arrive and hi_first belongs to node n
typedef struct packed {
	logic [0:3][0:3][15:0] ts;
	logic [0:3][15:0] flags;
	logic [3:0] arrive;
	logic [3:0] hi_first;
	logic [15:0] snap_tx;
	logic [15:0] snap_rx;
	logic back_pressure;
} sync_case_t;

localparam int N_CASES = 6;

localparam sync_case_t CASES [N_CASES] = '{
	// all nodes in order with every flag set
	'{ts: {16'h1111, 16'h0222, 16'h0033, 16'h0004, 16'h2345, 16'h1001, 16'h0f0f, 16'h00f0,
		16'h3456, 16'h0102, 16'h2020, 16'h0303, 16'h1357, 16'h0246, 16'h0a0a, 16'h0b0b},
		flags: {16'h0007, 16'h0007, 16'h0007, 16'h0007}, arrive: 4'b1111, hi_first: 4'b0000,
		snap_tx: 16'h0100, snap_rx: 16'h0900, back_pressure: 1'b0},
	// bit 14 patterns 0100, 0010, 0111 and 0001 for nodes 0 to 3
	'{ts: {16'h1234, 16'h0321, 16'h2100, 16'h0456, 16'h0abc, 16'h4def, 16'h5001, 16'h1a2b,
		16'h6543, 16'hc210, 16'h0777, 16'h3003, 16'h4111, 16'h2222, 16'h9abc, 16'h8765},
		flags: {16'h0001, 16'h0001, 16'h0001, 16'h0001}, arrive: 4'b1111, hi_first: 4'b0000,
		snap_tx: 16'h7000, snap_rx: 16'h0100, back_pressure: 1'b0},
	// node 1 never sends
	'{ts: {16'h2468, 16'h1357, 16'h0808, 16'h0909, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'hfedc, 16'h7654, 16'h3210, 16'h0f00, 16'h8001, 16'h4002, 16'h2003, 16'h1004},
		flags: {16'h0007, 16'h0007, 16'h0007, 16'h0007}, arrive: 4'b1101, hi_first: 4'b0000,
		snap_tx: 16'h5555, snap_rx: 16'haaaa, back_pressure: 1'b0},
	// node 1 sends its high bytes first
	'{ts: {16'h0f0e, 16'h0d0c, 16'h0b0a, 16'h0908, 16'h7766, 16'h5544, 16'h3322, 16'h1100,
		16'hc0de, 16'hbeef, 16'hface, 16'h0123, 16'h4567, 16'h89ab, 16'hcdef, 16'h0246},
		flags: {16'h0007, 16'h0007, 16'h0007, 16'h0007}, arrive: 4'b1111, hi_first: 4'b0010,
		snap_tx: 16'h0a0a, snap_rx: 16'h4b4b, back_pressure: 1'b0},
	// no writes at all, results come from the previous contents
	'{ts: {16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		flags: {16'h0000, 16'h0000, 16'h0000, 16'h0000}, arrive: 4'b0000, hi_first: 4'b0000,
		snap_tx: 16'h4444, snap_rx: 16'h4000, back_pressure: 1'b0},
	// flag selection under random back-pressure
	'{ts: {16'h3141, 16'h5926, 16'h5358, 16'h9793, 16'h2384, 16'h6264, 16'h3383, 16'h2795,
		16'h0288, 16'h4197, 16'h1693, 16'h9937, 16'h5105, 16'h8209, 16'h7494, 16'h4592},
		flags: {16'h0007, 16'h0102, 16'h0001, 16'h0a04}, arrive: 4'b1111, hi_first: 4'b0000,
		snap_tx: 16'h6180, snap_rx: 16'h3398, back_pressure: 1'b1}
};

`endif

//--- tests/master_sync_tb.sv
`timescale 1ns/1ps

module master_sync_tb;
	import clock_sync_pkg::*;

	localparam int NODES = 4;
	localparam int BASE_ADDR = 64;
	localparam int MSG_LEN = 16;
	localparam int TIMEOUT = 2000;

	`include "master_sync_vectors.svh"

	logic clk_i;
	logic rst_n_i;
	logic rx_we_i;
	addr_t rx_addr_i;
	byte_t rx_data_i;
	logic cycle_pulse_i;
	ts_t snap_tx_i;
	ts_t snap_rx_i;
	logic result_ready_i;
	logic [NODES-1:0] rx_ok_o;
	logic [NODES-1:0] sync_ok_o;
	logic [NODES-1:0] slave_rdy_o;
	logic [NODES-1:0] scope_trigger_o;
	logic result_valid_o;
	logic [$clog2(NODES)-1:0] result_node_o;
	ts_t result_offset_o;
	ts_t result_delay_o;
	logic busy_o;

	// timestamps the DUT should hold after the writes so far
	ts_t shadow [NODES][SLOTS_PER_NODE];
	integer seed;
	logic [31:0] rnd;

	master_sync #(
		.NODES(NODES),
		.BASE_ADDR(BASE_ADDR),
		.MSG_LEN(MSG_LEN)
	) u_master_sync (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rx_we_i(rx_we_i),
		.rx_addr_i(rx_addr_i),
		.rx_data_i(rx_data_i),
		.cycle_pulse_i(cycle_pulse_i),
		.snap_tx_i(snap_tx_i),
		.snap_rx_i(snap_rx_i),
		.result_ready_i(result_ready_i),
		.rx_ok_o(rx_ok_o),
		.sync_ok_o(sync_ok_o),
		.slave_rdy_o(slave_rdy_o),
		.scope_trigger_o(scope_trigger_o),
		.result_valid_o(result_valid_o),
		.result_node_o(result_node_o),
		.result_offset_o(result_offset_o),
		.result_delay_o(result_delay_o),
		.busy_o(busy_o)
	);

	always #10 clk_i = ~clk_i;

	// ============================================================
	// helpers
	// ============================================================

	task automatic check_value(input logic ok, input string msg);
		assert (ok) else begin
			$display("Mismatch at %0t: %s", $time, msg);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic write_byte(input int addr, input byte_t data);
		@(posedge clk_i);
		rx_we_i <= 1'b1;
		rx_addr_i <= addr_t'(addr);
		rx_data_i <= data;
	endtask

	task automatic send_node(input sync_case_t tc, input int n);
		int base;
		base = BASE_ADDR + n * MSG_LEN;
		write_byte(base + FLAGS_OFS, tc.flags[n][7:0]);
		write_byte(base + FLAGS_OFS + 1, tc.flags[n][15:8]);
		if (tc.hi_first[n]) begin
			for (int k = 0; k < SLOTS_PER_NODE; k++)
				write_byte(base + TS_OFS + 2 * k + 1, tc.ts[n][k][15:8]);
			for (int k = 0; k < SLOTS_PER_NODE; k++)
				write_byte(base + TS_OFS + 2 * k, tc.ts[n][k][7:0]);
		end else begin
			for (int k = 0; k < SLOTS_PER_NODE; k++) begin
				write_byte(base + TS_OFS + 2 * k, tc.ts[n][k][7:0]);
				write_byte(base + TS_OFS + 2 * k + 1, tc.ts[n][k][15:8]);
			end
		end
		for (int k = 0; k < SLOTS_PER_NODE; k++)
			shadow[n][k] = tc.ts[n][k];
	endtask

	// a node is complete only in order, with low bytes ahead of high bytes
	task automatic check_status(input sync_case_t tc);
		logic [NODES-1:0] comp;
		logic [NODES-1:0] sync;
		logic [NODES-1:0] rdy;
		logic [NODES-1:0] scope;
		comp = '0;
		for (int n = 0; n < NODES; n++) begin
			comp[n] = tc.arrive[n] && !tc.hi_first[n] && ((n == 0) ? 1'b1 : comp[n-1]);
			sync[n] = comp[n] && tc.flags[n][FLAG_SYNC];
			rdy[n] = sync[n] && tc.flags[n][FLAG_READY];
			scope[n] = comp[n] && tc.flags[n][FLAG_SCOPE];
		end
		check_value(rx_ok_o == comp, $sformatf("rx_ok_o %b expected %b", rx_ok_o, comp));
		check_value(sync_ok_o == sync, $sformatf("sync_ok_o %b expected %b", sync_ok_o, sync));
		check_value(slave_rdy_o == rdy, $sformatf("slave_rdy_o %b expected %b", slave_rdy_o, rdy));
		check_value(scope_trigger_o == scope,
			$sformatf("scope_trigger_o %b expected %b", scope_trigger_o, scope));
	endtask

	task automatic compute_expected(input sync_case_t tc, input int n,
		output ts_t off, output ts_t dly);
		ts_t a;
		ts_t b;
		ts_t c;
		ts_t d;
		logic [3:0] pattern;
		a = shadow[n][0];
		b = shadow[n][1];
		if (n == 0) begin
			c = tc.snap_tx;
			d = tc.snap_rx;
		end else begin
			c = shadow[n-1][2];
			d = shadow[n-1][3];
		end
		dly = a - b - c + d;
		off = a + b - c - d;
		pattern = {d[14], c[14], b[14], a[14]};
		if (pattern == 4'b0100 || pattern == 4'b0010 || pattern == 4'b0111)
			off = off + 16'h8000;
	endtask

	task automatic collect_results(input sync_case_t tc);
		int idx;
		int waited;
		logic held;
		ts_t exp_off;
		ts_t exp_dly;
		idx = 0;
		waited = 0;
		held = 1'b0;
		while (idx < NODES) begin
			@(posedge clk_i);
			if (tc.back_pressure) begin
				rnd = $random(seed);
				result_ready_i <= rnd[0];
			end else begin
				result_ready_i <= 1'b1;
			end
			@(negedge clk_i);
			waited++;
			// a result that was refused must still be offered
			check_value(!held || result_valid_o,
				$sformatf("node %0d result_valid_o dropped while waiting", idx));
			if (result_valid_o) begin
				compute_expected(tc, idx, exp_off, exp_dly);
				check_value(result_node_o == idx,
					$sformatf("result_node_o %0d expected %0d", result_node_o, idx));
				check_value(result_offset_o == exp_off, $sformatf("node %0d offset %h expected %h",
					idx, result_offset_o, exp_off));
				check_value(result_delay_o == exp_dly, $sformatf("node %0d delay %h expected %h",
					idx, result_delay_o, exp_dly));
				held = !result_ready_i;
				if (result_ready_i) begin
					idx++;
					waited = 0;
				end
			end
			if (waited > TIMEOUT)
				report_timeout($sformatf("the result of node %0d", idx));
		end
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		rx_we_i = 1'b0;
		rx_addr_i = '0;
		rx_data_i = '0;
		cycle_pulse_i = 1'b0;
		snap_tx_i = '0;
		snap_rx_i = '0;
		result_ready_i = 1'b0;
		seed = 11;
		repeat (5) @(posedge clk_i);
		rst_n_i <= 1'b1;
		@(negedge clk_i);
		check_value(rx_ok_o == '0 && sync_ok_o == '0 && slave_rdy_o == '0 &&
			scope_trigger_o == '0, "status vectors not clear after reset");
		check_value(!result_valid_o && !busy_o, "result_valid_o or busy_o set after reset");
		for (int i = 0; i < N_CASES; i++) begin
			for (int n = 0; n < NODES; n++) begin
				if (CASES[i].arrive[n])
					send_node(CASES[i], n);
			end
			@(posedge clk_i);
			rx_we_i <= 1'b0;
			cycle_pulse_i <= 1'b1;
			snap_tx_i <= CASES[i].snap_tx;
			snap_rx_i <= CASES[i].snap_rx;
			@(posedge clk_i);
			cycle_pulse_i <= 1'b0;
			@(negedge clk_i);
			check_status(CASES[i]);
			check_value(busy_o, $sformatf("case %0d sweep did not start", i));
			collect_results(CASES[i]);
			@(posedge clk_i);
			result_ready_i <= 1'b0;
			@(negedge clk_i);
			check_value(!busy_o, $sformatf("case %0d sequencer busy after last result", i));
		end
		$display("All tests passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+tests
common/clock_sync_pkg.sv
master_sync/mailbox_decoder.sv
master_sync/timestamp_ram.sv
master_sync/offset_delay_seq.sv
master_sync/master_sync.sv
tests/master_sync_tb.sv
